//--- hdl/decodeStage.sv
// Branches resolve here and default to not-taken; an operand still in flight stalls the branch
`default_nettype none

module decodeStage import rvIsaPkg::*, rvPipePkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         memStall,
	input  wordT         idPc,
	input  wordT         idInstr,
	wbForwardIf.consumer fwd,
	output logic         hazardStall,
	output logic         branchTaken,
	output wordT         branchTarget,
	output idExT         idEx
);

	opcodeT     opcode;
	regAddrT    rs1;
	regAddrT    rs2;
	regAddrT    rd;
	logic [2:0] funct3;
	logic       altForm;
	ctrlT       ctrl;
	wordT       imm;
	wordT       rs1Data;
	wordT       rs2Data;
	wordT       rs1Val;
	wordT       rs2Val;
	logic       isBranch;
	logic       useRs2;
	logic       loadUse;
	logic       exHit;
	logic       meLoadHit;
	logic       regEq;

	assign opcode  = opcodeT'(idInstr[6:0]);
	assign rd      = idInstr[rdLsb +: 5];
	assign funct3  = idInstr[funct3Lsb +: 3];
	assign rs1     = idInstr[rs1Lsb +: 5];
	assign rs2     = idInstr[rs2Lsb +: 5];
	assign altForm = idInstr[altBit];

	regFile regFile_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1Data  (rs1Data),
		.rs2Data  (rs2Data),
		.wb       (fwd),
		.memStall (memStall)
	);

	// ========================================
	// Control and immediate decode
	// ========================================
	always_comb begin
		ctrl = '0;
		isBranch = 1'b0;
		useRs2 = 1'b0;
		case (opcode)
			OP: begin
				ctrl.regWrite = 1'b1;
				useRs2 = 1'b1;
			end
			OP_IMM: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			LOAD: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			STORE: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				useRs2 = 1'b1;
			end
			BRANCH: begin
				isBranch = 1'b1;
				useRs2 = 1'b1;
			end
			default: ; // Unknown opcode runs as a bubble
		endcase
		if (opcode == OP || opcode == OP_IMM) begin
			case (funct3)
				funct3Add: ctrl.aluOp = (opcode == OP && altForm) ? aluSub : aluAdd;
				funct3Sll: ctrl.aluOp = aluSll;
				funct3Slt: ctrl.aluOp = aluSlt;
				funct3Xor: ctrl.aluOp = aluXor;
				funct3Sr:  ctrl.aluOp = altForm ? aluSra : aluSrl;
				funct3Or:  ctrl.aluOp = aluOr;
				funct3And: ctrl.aluOp = aluAnd;
				default:   ctrl.aluOp = aluAdd;
			endcase
		end
	end

	always_comb begin
		case (opcode)
			STORE:   imm = {{20{idInstr[31]}}, idInstr[31:25], idInstr[11:7]};
			BRANCH:  imm = {{20{idInstr[31]}}, idInstr[7], idInstr[30:25], idInstr[11:8], 1'b0};
			default: imm = {{20{idInstr[31]}}, idInstr[31:20]};
		endcase
	end

	// ========================================
	// Branch resolution and hazards
	// ========================================
	function automatic logic srcHit(input regAddrT dst);
		return dst != '0 && (dst == rs1 || (useRs2 && dst == rs2));
	endfunction

	// Write-back values already arrive through the register file bypass
	assign rs1Val = (fwd.meRegWrite && fwd.meRd != '0 && fwd.meRd == rs1) ?
		fwd.meResult : rs1Data;
	assign rs2Val = (fwd.meRegWrite && fwd.meRd != '0 && fwd.meRd == rs2) ?
		fwd.meResult : rs2Data;
	assign regEq = rs1Val == rs2Val;
	assign branchTarget = idPc + imm;

	always_comb begin
		loadUse = idEx.ctrl.memRead && srcHit(idEx.rd);
		exHit = idEx.ctrl.regWrite && srcHit(idEx.rd);
		meLoadHit = fwd.meMemRead && fwd.meRegWrite && srcHit(fwd.meRd);
		hazardStall = loadUse || (isBranch && (exHit || meLoadHit));
		branchTaken = isBranch && !hazardStall &&
			((funct3 == funct3Beq && regEq) || (funct3 == funct3Bne && !regEq));
	end

	// ID/EX register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idEx <= '0;
		end else if (!memStall) begin
			if (hazardStall) begin
				idEx <= '0; // Bubble
			end else begin
				idEx.ctrl <= ctrl;
				idEx.rs1 <= rs1;
				idEx.rs2 <= rs2;
				idEx.rs1Data <= rs1Data;
				idEx.rs2Data <= rs2Data;
				idEx.imm <= imm;
				idEx.rd <= rd;
			end
		end
	end

	// The flushed slot decodes as a NOP that never stalls
	stallNotFlush: assert property (@(posedge clk) disable iff (!rst_n)
		branchTaken && !memStall |=> !hazardStall);

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
// Relies on the load-use stall, so the memory-stage forward is always an ALU result
`default_nettype none

module executeStage import rvIsaPkg::*, rvPipePkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         memStall,
	input  idExT         idEx,
	wbForwardIf.consumer fwd,
	output exMemT        exMem
);

	wordT       opA;
	wordT       opB;
	wordT       storeData;
	wordT       result;
	logic [4:0] shamt;

	// Memory stage wins over write-back
	function automatic wordT pickOperand(input regAddrT src, input wordT regData);
		if (fwd.meRegWrite && fwd.meRd != '0 && fwd.meRd == src)
			return fwd.meResult;
		if (fwd.wbRegWrite && fwd.wbRd != '0 && fwd.wbRd == src)
			return fwd.wbData;
		return regData;
	endfunction

	// ========================================
	// Operands and ALU
	// ========================================
	always_comb begin
		opA = pickOperand(idEx.rs1, idEx.rs1Data);
		storeData = pickOperand(idEx.rs2, idEx.rs2Data);
		opB = idEx.ctrl.aluSrc ? idEx.imm : storeData;
		shamt = opB[4:0];
		case (idEx.ctrl.aluOp)
			aluSub:  result = opA - opB;
			aluSll:  result = opA << shamt;
			aluSlt:  result = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
			aluXor:  result = opA ^ opB;
			aluSrl:  result = opA >> shamt;
			aluSra:  result = wordT'($signed(opA) >>> shamt);
			aluOr:   result = opA | opB;
			aluAnd:  result = opA & opB;
			default: result = opA + opB; // add, also load/store address
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exMem <= '0;
		end else if (!memStall) begin
			exMem.memRead <= idEx.ctrl.memRead;
			exMem.memWrite <= idEx.ctrl.memWrite;
			exMem.memToReg <= idEx.ctrl.memToReg;
			exMem.regWrite <= idEx.ctrl.regWrite;
			exMem.aluResult <= result;
			exMem.storeData <= storeData; // Forwarded rs2
			exMem.rd <= idEx.rd;
		end
	end

endmodule

`default_nettype wire

//--- hdl/fetchStage.sv
// PC starts at 0 after reset; imemRdata must belong to imemAddr in the same cycle
`default_nettype none

module fetchStage import rvIsaPkg::*, rvPipePkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     memStall,
	input  logic     hazardStall,
	input  logic     branchTaken,
	input  wordT     branchTarget,
	output wordAddrT imemAddr,
	input  wordT     imemRdata,
	output wordT     idPc,
	output wordT     idInstr
);

	wordT pc;

	assign imemAddr = pc[xlen-1:2];

	// PC and IF/ID
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			idPc <= '0;
			idInstr <= nopInstr;
		end else if (!memStall && !hazardStall) begin
			idPc <= pc;
			if (branchTaken) begin
				pc <= branchTarget;
				idInstr <= nopInstr; // Squash the wrong-path fetch
			end else begin
				pc <= pc + 32'd4;
				idInstr <= imemRdata;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/memWbStage.sv
// Data access completes on the first edge with the stall low; dmemRdata is sampled then
`default_nettype none

module memWbStage import rvPipePkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       memStall,
	input  exMemT      exMem,
	output logic       dmemRead,
	output logic       dmemWrite,
	output wordAddrT   dmemAddr,
	output wordT       dmemWdata,
	input  wordT       dmemRdata,
	wbForwardIf.source fwd
);

	regAddrT wbRd;
	logic    wbRegWrite;
	logic    wbMemToReg;
	wordT    wbAlu;
	wordT    wbLoad;

	// Data port straight from EX/MEM
	assign dmemRead  = exMem.memRead;
	assign dmemWrite = exMem.memWrite;
	assign dmemAddr  = exMem.aluResult[$bits(wordT)-1:2];
	assign dmemWdata = exMem.storeData;

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wbRd <= '0;
			wbRegWrite <= 1'b0;
			wbMemToReg <= 1'b0;
		end else if (!memStall) begin
			wbRd <= exMem.rd;
			wbRegWrite <= exMem.regWrite;
			wbMemToReg <= exMem.memToReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!memStall) begin
			wbAlu <= exMem.aluResult;
			wbLoad <= dmemRdata;
		end
	end

	assign fwd.meRd       = exMem.rd;
	assign fwd.meRegWrite = exMem.regWrite;
	assign fwd.meMemRead  = exMem.memRead;
	assign fwd.meResult   = exMem.aluResult;
	assign fwd.wbRd       = wbRd;
	assign fwd.wbRegWrite = wbRegWrite;
	assign fwd.wbData     = wbMemToReg ? wbLoad : wbAlu;

	noReadWrite: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmemRead && dmemWrite));

	// Request held steady through a freeze
	heldRequest: assert property (@(posedge clk) disable iff (!rst_n)
		memStall && (dmemRead || dmemWrite) |=>
			$stable({dmemRead, dmemWrite, dmemAddr, dmemWdata}));

endmodule

`default_nettype wire

//--- hdl/regFile.sv
// x0 reads zero; a read of the register written this cycle returns the write data
`default_nettype none

module regFile import rvPipePkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  regAddrT      rs1,
	input  regAddrT      rs2,
	output wordT         rs1Data,
	output wordT         rs2Data,
	wbForwardIf.consumer wb,
	input  logic         memStall
);

	wordT regs [1:31];

	function automatic wordT readPort(input regAddrT idx);
		if (idx == '0)
			return '0;
		if (wb.wbRegWrite && wb.wbRd == idx)
			return wb.wbData; // Write-through bypass
		return regs[idx];
	endfunction

	always_comb begin
		rs1Data = readPort(rs1);
		rs2Data = readPort(rs2);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.wbRegWrite && wb.wbRd != '0 && !memStall) begin
			regs[wb.wbRd] <= wb.wbData;
		end
	end

endmodule

`default_nettype wire

//--- hdl/rvCore.sv
// Either memory stall freezes the whole pipeline; no caches, ports are word addressed
`default_nettype none

module rvCore import rvPipePkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	output wordAddrT imemAddr,
	input  wordT     imemRdata,
	input  logic     imemStall,
	output logic     dmemRead,
	output logic     dmemWrite,
	output wordAddrT dmemAddr,
	output wordT     dmemWdata,
	input  wordT     dmemRdata,
	input  logic     dmemStall
);

	logic  memStall;
	logic  hazardStall;
	logic  branchTaken;
	wordT  branchTarget;
	wordT  idPc;
	wordT  idInstr;
	idExT  idEx;
	exMemT exMem;

	wbForwardIf fwdBus ();

	assign memStall = imemStall | dmemStall; // Global freeze

	fetchStage fetchStage_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.memStall     (memStall),
		.hazardStall  (hazardStall),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.imemAddr     (imemAddr),
		.imemRdata    (imemRdata),
		.idPc         (idPc),
		.idInstr      (idInstr)
	);

	decodeStage decodeStage_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.memStall     (memStall),
		.idPc         (idPc),
		.idInstr      (idInstr),
		.fwd          (fwdBus),
		.hazardStall  (hazardStall),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.idEx         (idEx)
	);

	executeStage executeStage_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.memStall (memStall),
		.idEx     (idEx),
		.fwd      (fwdBus),
		.exMem    (exMem)
	);

	memWbStage memWbStage_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.memStall  (memStall),
		.exMem     (exMem),
		.dmemRead  (dmemRead),
		.dmemWrite (dmemWrite),
		.dmemAddr  (dmemAddr),
		.dmemWdata (dmemWdata),
		.dmemRdata (dmemRdata),
		.fwd       (fwdBus)
	);

endmodule

`default_nettype wire

//--- hdl/rvIsaPkg.sv
// RV32I subset: ALU ops, lw/sw, beq/bne only; unlisted funct3 codes fall back to add or not-taken
`default_nettype none

package rvIsaPkg;

	localparam int xlen = 32;

	// Major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011
	} opcodeT;

	// Bit 3 set on the alternate forms
	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSll = 4'b0001,
		aluSlt = 4'b0010,
		aluXor = 4'b0100,
		aluSrl = 4'b0101,
		aluOr  = 4'b0110,
		aluAnd = 4'b0111,
		aluSub = 4'b1000,
		aluSra = 4'b1101
	} aluOpT;

	// Field positions
	localparam int rdLsb     = 7;
	localparam int funct3Lsb = 12;
	localparam int rs1Lsb    = 15;
	localparam int rs2Lsb    = 20;
	localparam int altBit    = 30; // funct7[5]

	localparam logic [2:0] funct3Beq = 3'b000;
	localparam logic [2:0] funct3Bne = 3'b001;
	localparam logic [2:0] funct3Add = 3'b000;
	localparam logic [2:0] funct3Sll = 3'b001;
	localparam logic [2:0] funct3Slt = 3'b010;
	localparam logic [2:0] funct3Xor = 3'b100;
	localparam logic [2:0] funct3Sr  = 3'b101; // srl and sra
	localparam logic [2:0] funct3Or  = 3'b110;
	localparam logic [2:0] funct3And = 3'b111;

	localparam logic [xlen-1:0] nopInstr = 32'h0000_0013; // addi x0,x0,0

endpackage

`default_nettype wire

//--- hdl/rvPipePkg.sv
// Memory is word addressed only; byte offsets are dropped and no byte enables exist
`default_nettype none

package rvPipePkg;

	import rvIsaPkg::*;

	typedef logic [xlen-1:0] wordT;
	typedef logic [xlen-3:0] wordAddrT; // Byte address without bits [1:0]
	typedef logic [4:0]      regAddrT;

	typedef struct packed {
		aluOpT aluOp;
		logic  aluSrc;   // Immediate as operand B
		logic  memRead;
		logic  memWrite;
		logic  memToReg;
		logic  regWrite;
	} ctrlT;

	typedef struct packed {
		ctrlT    ctrl;
		regAddrT rs1;
		regAddrT rs2;
		wordT    rs1Data;
		wordT    rs2Data;
		wordT    imm;
		regAddrT rd;
	} idExT;

	typedef struct packed {
		logic    memRead;
		logic    memWrite;
		logic    memToReg;
		logic    regWrite;
		wordT    aluResult;
		wordT    storeData;
		regAddrT rd;
	} exMemT;

endpackage

`default_nettype wire

//--- hdl/wbForwardIf.sv
// Memory-stage result is the ALU value; a load there must be covered by the hazard stall
`default_nettype none

interface wbForwardIf import rvPipePkg::*; ();

	// Memory stage
	regAddrT meRd;
	logic    meRegWrite;
	logic    meMemRead;
	wordT    meResult;

	// Write-back stage
	regAddrT wbRd;
	logic    wbRegWrite;
	wordT    wbData;

	modport source (output meRd, meRegWrite, meMemRead, meResult, wbRd, wbRegWrite, wbData);
	modport consumer (input meRd, meRegWrite, meMemRead, meResult, wbRd, wbRegWrite, wbData);

endinterface

`default_nettype wire

//--- testbench/rvCoreTb.sv
// 16-word ROM and RAM models; stores to word 8 and up are markers and are never checked
`default_nettype none

module rvCoreTb import rvIsaPkg::*, rvPipePkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int baseRows     = 4;
	localparam int numRows      = 2 * baseRows; // Second half reruns with stalls
	localparam int progLen      = 12;
	localparam int memWords     = 16;
	localparam int markerBase   = 8;
	localparam int cyclesPerRow = 200;
	localparam int clkPeriodNs  = 8;

	logic        clk;
	logic        rst_n;
	logic        resetReq;
	wordAddrT    imemAddr;
	wordT        imemRdata;
	logic        imemStall;
	logic        dmemRead;
	logic        dmemWrite;
	wordAddrT    dmemAddr;
	wordT        dmemWdata;
	wordT        dmemRdata;
	logic        dmemStall;
	logic        stallOn;
	int unsigned seedVal;

	wordT rom [memWords];
	wordT dmem [memWords];

	// Test table
	string    rowName [numRows];
	wordT     rowProg [numRows][progLen];
	wordT     rowData [numRows][4];
	bit       rowStall [numRows];
	wordAddrT rowAddr [numRows];
	wordT     rowExp [numRows];

	tbClock tbClock_inst (.resetReq(resetReq), .clk(clk), .rst_n(rst_n));

	rvCore rvCore_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.imemAddr  (imemAddr),
		.imemRdata (imemRdata),
		.imemStall (imemStall),
		.dmemRead  (dmemRead),
		.dmemWrite (dmemWrite),
		.dmemAddr  (dmemAddr),
		.dmemWdata (dmemWdata),
		.dmemRdata (dmemRdata),
		.dmemStall (dmemStall)
	);

	// ========================================
	// Memory models
	// ========================================
	function automatic wordT fillPattern(input wordAddrT addr);
		return {2'b10, addr};
	endfunction

	assign imemRdata = imemStall ? 32'hDEAD_BEEF : // Garbage while stalled
		(imemAddr < memWords) ? rom[imemAddr[3:0]] : nopInstr;
	assign dmemRdata = (dmemAddr < memWords) ? dmem[dmemAddr[3:0]] : fillPattern(dmemAddr);

	always @(posedge clk) begin
		if (rst_n && dmemWrite && !dmemStall && dmemAddr < memWords)
			dmem[dmemAddr[3:0]] <= dmemWdata;
	end

	// Random stalls, one in four per port
	initial begin
		imemStall = 1'b0;
		dmemStall = 1'b0;
		seedVal = $urandom(57);
		forever begin
			@(posedge clk);
			if (stallOn) begin
				imemStall <= ($urandom % 4) == 0;
				dmemStall <= ($urandom % 4) == 0;
			end else begin
				imemStall <= 1'b0;
				dmemStall <= 1'b0;
			end
		end
	end

	// ========================================
	// Instruction encoders
	// ========================================
	function automatic wordT encodeR(input logic [6:0] funct7, input regAddrT rs2,
			input regAddrT rs1, input logic [2:0] funct3, input regAddrT rd);
		return {funct7, rs2, rs1, funct3, rd, OP};
	endfunction

	function automatic wordT encodeI(input logic [11:0] imm, input regAddrT rs1,
			input logic [2:0] funct3, input regAddrT rd, input opcodeT opc);
		return {imm, rs1, funct3, rd, opc};
	endfunction

	function automatic wordT encodeS(input logic [11:0] imm, input regAddrT rs2,
			input regAddrT rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE}; // sw only
	endfunction

	function automatic wordT encodeB(input logic [12:0] off, input regAddrT rs2,
			input regAddrT rs1, input logic [2:0] funct3);
		return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], BRANCH};
	endfunction

	task automatic buildTable();
		// ALU chain, ends with x11 = 0x580 stored at word 1
		rowName[0] = "aluChain";
		rowProg[0] = '{
			encodeI(12'd100, 5'd0, funct3Add, 5'd1, OP_IMM),  // x1 = 100
			encodeI(12'hFF9, 5'd0, funct3Add, 5'd2, OP_IMM),  // x2 = -7
			encodeR(7'h00, 5'd2, 5'd1, funct3Add, 5'd3),      // x3 = 93
			encodeR(7'h20, 5'd1, 5'd2, funct3Add, 5'd4),      // x4 = -107
			encodeR(7'h00, 5'd1, 5'd3, funct3Sll, 5'd5),      // x5 = 0x5D0
			encodeR(7'h00, 5'd3, 5'd4, funct3Slt, 5'd6),      // x6 = 1
			encodeR(7'h00, 5'd4, 5'd5, funct3Xor, 5'd7),      // x7 = 0xFFFFFA45
			encodeR(7'h00, 5'd6, 5'd7, funct3Sr, 5'd8),       // x8 = 0x7FFFFD22
			encodeR(7'h20, 5'd1, 5'd7, funct3Sr, 5'd9),       // x9 = 0xFFFFFFA4
			encodeR(7'h00, 5'd9, 5'd8, funct3Or, 5'd10),      // x10 = 0xFFFFFFA6
			encodeR(7'h00, 5'd5, 5'd10, funct3And, 5'd11),
			encodeS(12'd4, 5'd11, 5'd0)};
		rowData[0] = '{32'h0, 32'h0, 32'h0, 32'h0};
		rowAddr[0] = 30'd1;
		rowExp[0] = 32'h0000_0580;

		rowName[1] = "loadUse";
		rowProg[1] = '{
			encodeI(12'h123, 5'd0, funct3Add, 5'd3, OP_IMM),
			encodeS(12'd32, 5'd3, 5'd0),                      // Marker at word 8
			encodeI(12'd8, 5'd0, 3'b010, 5'd1, LOAD),         // lw x1, 8(x0)
			encodeR(7'h00, 5'd3, 5'd1, funct3Add, 5'd2),
			encodeS(12'd12, 5'd2, 5'd0),
			nopInstr, nopInstr, nopInstr, nopInstr, nopInstr, nopInstr, nopInstr};
		rowData[1] = '{32'h1111_0000, 32'h0000_1234, 32'hCAFE_F00D, 32'h0BAD_BEEF};
		rowAddr[1] = 30'd3;
		rowExp[1] = 32'hCAFE_F130;

		// Wrong paths add 1 or 4, right path sums to 26
		rowName[2] = "branches";
		rowProg[2] = '{
			encodeI(12'd5, 5'd0, funct3Add, 5'd1, OP_IMM),
			encodeI(12'd5, 5'd0, funct3Add, 5'd2, OP_IMM),
			encodeB(13'd8, 5'd2, 5'd1, funct3Beq),            // Taken
			encodeI(12'd1, 5'd5, funct3Add, 5'd5, OP_IMM),
			encodeI(12'd2, 5'd5, funct3Add, 5'd5, OP_IMM),
			encodeB(13'd8, 5'd1, 5'd5, funct3Bne),            // Taken
			encodeI(12'd4, 5'd5, funct3Add, 5'd5, OP_IMM),
			encodeI(12'd8, 5'd5, funct3Add, 5'd5, OP_IMM),
			encodeB(13'd8, 5'd1, 5'd5, funct3Beq),            // Not taken
			encodeI(12'd16, 5'd5, funct3Add, 5'd5, OP_IMM),
			encodeB(13'd8, 5'd5, 5'd5, funct3Bne),            // Not taken
			encodeS(12'd8, 5'd5, 5'd0)};
		rowData[2] = '{32'h0, 32'h0, 32'h0, 32'h0};
		rowAddr[2] = 30'd2;
		rowExp[2] = 32'h0000_001A;

		rowName[3] = "zeroReg";
		rowProg[3] = '{
			encodeI(12'd77, 5'd0, funct3Add, 5'd0, OP_IMM),   // Discarded
			encodeI(12'hF00, 5'd0, funct3Add, 5'd1, OP_IMM),  // x1 = -256
			encodeI(12'h0F0, 5'd1, funct3Xor, 5'd2, OP_IMM),  // x2 = 0xFFFFFFF0
			encodeI(12'h402, 5'd2, funct3Sr, 5'd3, OP_IMM),   // srai, x3 = -4
			encodeI(12'h01C, 5'd3, funct3Sr, 5'd4, OP_IMM),   // srli, x4 = 0xF
			encodeI(12'h004, 5'd4, funct3Sll, 5'd5, OP_IMM),  // x5 = 0xF0
			encodeI(12'h005, 5'd5, funct3Or, 5'd6, OP_IMM),   // x6 = 0xF5
			encodeI(12'h0F7, 5'd6, funct3And, 5'd7, OP_IMM),  // x7 = 0xF5
			encodeR(7'h00, 5'd7, 5'd7, funct3Add, 5'd0),      // Discarded
			encodeI(12'h001, 5'd0, funct3Slt, 5'd8, OP_IMM),  // x8 = 1 only if x0 is 0
			encodeR(7'h00, 5'd8, 5'd7, funct3Add, 5'd9),
			encodeS(12'd0, 5'd9, 5'd0)};
		rowData[3] = '{32'h5555_AAAA, 32'h0, 32'h0, 32'h0};
		rowAddr[3] = 30'd0;
		rowExp[3] = 32'h0000_00F6;

		for (int r = 0; r < baseRows; r++) begin
			rowStall[r] = 1'b0;
			rowName[r + baseRows] = {rowName[r], "_stall"};
			rowProg[r + baseRows] = rowProg[r];
			rowData[r + baseRows] = rowData[r];
			rowStall[r + baseRows] = 1'b1;
			rowAddr[r + baseRows] = rowAddr[r];
			rowExp[r + baseRows] = rowExp[r];
		end
	endtask

	// ========================================
	// Checks
	// ========================================
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkAddr(input string name, input wordAddrT expected, input wordAddrT actual);
		if (actual !== expected)
			abortRun($sformatf("ERR %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected)
			abortRun($sformatf("ERR %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abortRun($sformatf("ERR %s expected %b actual %b", name, expected, actual));
	endtask

	// ========================================
	// Row sequencing
	// ========================================
	task automatic loadRow(input int r);
		for (int i = 0; i < memWords; i++) begin
			rom[i] = (i < progLen) ? rowProg[r][i] : nopInstr;
			dmem[i] = (i < 4) ? rowData[r][i] : fillPattern(wordAddrT'(i));
		end
		stallOn = rowStall[r];
	endtask

	task automatic applyReset(input int r);
		@(posedge clk);
		resetReq <= 1'b1;
		@(posedge clk);
		resetReq <= 1'b0;
		@(negedge clk); // rst_n is low here
		loadRow(r);
		while (!rst_n)
			@(negedge clk);
		checkFlag({rowName[r], " dmemRead"}, 1'b0, dmemRead);
		checkFlag({rowName[r], " dmemWrite"}, 1'b0, dmemWrite);
	endtask

	task automatic waitForStore(input int r);
		bit done;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			// Completes at the next edge, markers skipped
			if (dmemWrite && !dmemStall && dmemAddr < markerBase) begin
				checkAddr({rowName[r], " addr"}, rowAddr[r], dmemAddr);
				checkWord({rowName[r], " data"}, rowExp[r], dmemWdata);
				done = 1'b1;
			end
		end
	endtask

	initial begin
		resetReq = 1'b0;
		stallOn = 1'b0;
		buildTable();
		loadRow(0);
		for (int r = 0; r < numRows; r++) begin
			applyReset(r);
			waitForStore(r);
		end
		$display("Everything OK");
		$finish;
	end

	// Watchdog
	initial begin
		#(numRows * cyclesPerRow * clkPeriodNs);
		abortRun("Timeout: the program never stored its result");
	end

endmodule

`default_nettype wire

//--- testbench/tbClock.sv
// Clock period 8 ns; rst_n stays low for 2 cycles at power-on and after each resetReq
`default_nettype none

module tbClock (
	input  logic resetReq,
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [1:0] holdCycles = 2'd2; // Power-on reset

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (resetReq)
			holdCycles <= 2'd2;
		else if (holdCycles != 2'd0)
			holdCycles <= holdCycles - 2'd1;
	end

	assign rst_n = (holdCycles == 2'd0);

endmodule

`default_nettype wire

//--- vlog.f
hdl/rvIsaPkg.sv
hdl/rvPipePkg.sv
hdl/wbForwardIf.sv
hdl/regFile.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/rvCore.sv
testbench/tbClock.sv
testbench/rvCoreTb.sv
